/* axis_cfg_pkg.sv */
`default_nettype none

package axis_cfg_pkg;

    // Beat width in bytes
    localparam int DATA_BYTES_DEF = 4;

    // Number of routed output streams
    localparam int NUM_PORTS_DEF = 2;

    // One tkeep bit covers one lane of this width
    localparam int BYTE_W = 8;

endpackage

`default_nettype wire

/* axis_mode_pkg.sv */
`default_nettype none

package axis_mode_pkg;

    // PULL also fills an empty slice while downstream stalls
    typedef enum logic {PULL, PUSH} fwd_mode_t;

    // Advance stage holding state
    typedef enum logic {EMPTY, HOLD} adv_state_t;

    // Demux position relative to packet boundaries
    typedef enum logic {IDLE, IN_PKT} route_state_t;

endpackage

`default_nettype wire

/* axis_skid_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer #(
    parameter int DATA_BYTES = 4
) (
    input  wire                                     axi4s_if_from_tx,
    input  wire                                     aresetn,
    input  wire                                     in_tvalid,
    output logic                                    in_tready,
    input  wire [DATA_BYTES*axis_cfg_pkg::BYTE_W-1:0] in_tdata,
    input  wire [DATA_BYTES-1:0]                    in_tkeep,
    input  wire                                     in_tlast,
    output logic                                    out_tvalid,
    input  wire                                     out_tready,
    output logic [DATA_BYTES*axis_cfg_pkg::BYTE_W-1:0] out_tdata,
    output logic [DATA_BYTES-1:0]                   out_tkeep,
    output logic                                    out_tlast
);

    localparam int DATA_W = DATA_BYTES * axis_cfg_pkg::BYTE_W;

    logic                  rdy_q;
    logic                  fwft;
    logic                  capture;
    logic                  skid_valid;
    logic [DATA_W-1:0]     skid_data;
    logic [DATA_BYTES-1:0] skid_keep;
    logic                  skid_last;

    // Downstream ready seen one cycle late
    always_ff @(posedge axi4s_if_from_tx) begin
        if (!aresetn) begin
            rdy_q <= 1'b0;
        end else begin
            rdy_q <= out_tready;
        end
    end

    // Empty skid register can always take one word
    assign fwft      = in_tvalid && !skid_valid && !rdy_q;
    assign in_tready = rdy_q || fwft;

    // Word accepted but not taken downstream lands in the skid register
    assign capture = in_tready && !out_tready;

    always_ff @(posedge axi4s_if_from_tx) begin
        if (!aresetn) begin
            skid_valid <= 1'b0;
        end else if (skid_valid && out_tready) begin
            skid_valid <= 1'b0;
        end else if (capture) begin
            skid_valid <= in_tvalid;
        end
    end

    always_ff @(posedge axi4s_if_from_tx) begin
        if (!skid_valid) begin
            skid_data <= in_tdata;
            skid_keep <= in_tkeep;
            skid_last <= in_tlast;
        end
    end

    // Skid register has priority, else straight through
    always_comb begin
        if (skid_valid) begin
            out_tvalid = 1'b1;
            out_tdata  = skid_data;
            out_tkeep  = skid_keep;
            out_tlast  = skid_last;
        end else begin
            out_tvalid = in_tvalid;
            out_tdata  = in_tdata;
            out_tkeep  = in_tkeep;
            out_tlast  = in_tlast;
        end
    end

endmodule

`default_nettype wire

/* axis_fwd_register.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_fwd_register #(
    parameter int                       DATA_BYTES = 4,
    parameter axis_mode_pkg::fwd_mode_t PIPE_MODE  = axis_mode_pkg::PULL
) (
    input  wire                                     axi4s_if_from_tx,
    input  wire                                     aresetn,
    input  wire                                     in_tvalid,
    output logic                                    in_tready,
    input  wire [DATA_BYTES*axis_cfg_pkg::BYTE_W-1:0] in_tdata,
    input  wire [DATA_BYTES-1:0]                    in_tkeep,
    input  wire                                     in_tlast,
    output logic                                    out_tvalid,
    input  wire                                     out_tready,
    output logic [DATA_BYTES*axis_cfg_pkg::BYTE_W-1:0] out_tdata,
    output logic [DATA_BYTES-1:0]                   out_tkeep,
    output logic                                    out_tlast
);

    localparam int DATA_W = DATA_BYTES * axis_cfg_pkg::BYTE_W;

    // Slice free to take a beat regardless of downstream
    logic empty_q;

    logic [DATA_W-1:0] data_q;

    assign in_tready = (PIPE_MODE == axis_mode_pkg::PUSH) ? out_tready
                                                          : (empty_q || out_tready);
    assign out_tdata = data_q;

    always_ff @(posedge axi4s_if_from_tx) begin
        if (!aresetn) begin
            out_tvalid <= 1'b0;
            empty_q    <= 1'b1;
        end else if (in_tvalid && in_tready) begin
            out_tvalid <= 1'b1;
            empty_q    <= 1'b0;
        end else if (out_tready) begin
            out_tvalid <= 1'b0;
            empty_q    <= 1'b1;
        end
    end

    // Payload only moves on an input transfer
    always_ff @(posedge axi4s_if_from_tx) begin
        if (in_tvalid && in_tready) begin
            data_q    <= in_tdata;
            out_tkeep <= in_tkeep;
            out_tlast <= in_tlast;
        end
    end

endmodule

`default_nettype wire

/* axis_tlast_advance.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_tlast_advance #(
    parameter int                       DATA_BYTES = 4,
    parameter axis_mode_pkg::fwd_mode_t PIPE_MODE  = axis_mode_pkg::PULL
) (
    input  wire                                     axi4s_if_from_tx,
    input  wire                                     aresetn,
    input  wire                                     in_tvalid,
    output logic                                    in_tready,
    input  wire [DATA_BYTES*axis_cfg_pkg::BYTE_W-1:0] in_tdata,
    input  wire [DATA_BYTES-1:0]                    in_tkeep,
    input  wire                                     in_tlast,
    output logic                                    out_tvalid,
    input  wire                                     out_tready,
    output logic [DATA_BYTES*axis_cfg_pkg::BYTE_W-1:0] out_tdata,
    output logic [DATA_BYTES-1:0]                   out_tkeep,
    output logic                                    out_tlast
);

    localparam int DATA_W = DATA_BYTES * axis_cfg_pkg::BYTE_W;

    axis_mode_pkg::adv_state_t state;

    logic [DATA_W-1:0]     hold_data;
    logic [DATA_BYTES-1:0] hold_keep;
    logic                  hold_last;
    logic                  in_empty_last;
    logic                  load_hold;
    logic                  mid_tvalid;
    logic                  mid_tready;
    logic                  mid_tlast;

    assign in_empty_last = in_tlast && (in_tkeep == '0);

    // Nothing held means nothing blocks the input
    assign in_tready = (state == axis_mode_pkg::EMPTY) ? 1'b1 : mid_tready;
    assign load_hold = in_tvalid && in_tready && !in_empty_last;

    // Held beat goes once its successor is present, or alone if it ends the packet
    assign mid_tvalid = (state == axis_mode_pkg::HOLD) && (hold_last || in_tvalid);

    // Empty last beat folds its tlast into the held beat
    assign mid_tlast = hold_last || in_empty_last;

    always_ff @(posedge axi4s_if_from_tx) begin
        if (!aresetn) begin
            state <= axis_mode_pkg::EMPTY;
        end else if (load_hold) begin
            state <= axis_mode_pkg::HOLD;
        end else if (mid_tvalid && mid_tready) begin
            state <= axis_mode_pkg::EMPTY;
        end
    end

    always_ff @(posedge axi4s_if_from_tx) begin
        if (load_hold) begin
            hold_data <= in_tdata;
            hold_keep <= in_tkeep;
            hold_last <= in_tlast;
        end
    end

    axis_fwd_register #(
        .DATA_BYTES (DATA_BYTES),
        .PIPE_MODE  (PIPE_MODE)
    ) u_out_slice (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .in_tvalid        (mid_tvalid),
        .in_tready        (mid_tready),
        .in_tdata         (hold_data),
        .in_tkeep         (hold_keep),
        .in_tlast         (mid_tlast),
        .out_tvalid       (out_tvalid),
        .out_tready       (out_tready),
        .out_tdata        (out_tdata),
        .out_tkeep        (out_tkeep),
        .out_tlast        (out_tlast)
    );

endmodule

`default_nettype wire

/* axis_demux.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_demux #(
    parameter int                       DATA_BYTES = 4,
    parameter int                       NUM_PORTS  = 2,
    parameter axis_mode_pkg::fwd_mode_t PIPE_MODE  = axis_mode_pkg::PULL
) (
    input  wire                                  axi4s_if_from_tx,
    input  wire                                  aresetn,
    input  wire                                  in_tvalid,
    output logic                                 in_tready,
    input  wire [DATA_BYTES*axis_cfg_pkg::BYTE_W-1:0] in_tdata,
    input  wire [DATA_BYTES-1:0]                 in_tkeep,
    input  wire                                  in_tlast,
    input  wire [$clog2(NUM_PORTS)-1:0]          sel,
    output logic [NUM_PORTS-1:0]                 out_tvalid,
    input  wire [NUM_PORTS-1:0]                  out_tready,
    output logic [NUM_PORTS-1:0][DATA_BYTES*axis_cfg_pkg::BYTE_W-1:0] out_tdata,
    output logic [NUM_PORTS-1:0][DATA_BYTES-1:0] out_tkeep,
    output logic [NUM_PORTS-1:0]                 out_tlast
);

    localparam int SEL_W = $clog2(NUM_PORTS);

    axis_mode_pkg::route_state_t state;

    logic [SEL_W-1:0]     port_q;
    logic [SEL_W-1:0]     cur_port;
    logic [NUM_PORTS-1:0] slice_tvalid;
    logic [NUM_PORTS-1:0] slice_tready;

    // First beat follows sel, the rest of the packet the latched port
    assign cur_port  = (state == axis_mode_pkg::IDLE) ? sel : port_q;
    assign in_tready = slice_tready[cur_port];

    always_ff @(posedge axi4s_if_from_tx) begin
        if (!aresetn) begin
            state  <= axis_mode_pkg::IDLE;
            port_q <= '0;
        end else if (in_tvalid && in_tready) begin
            if (state == axis_mode_pkg::IDLE) begin
                port_q <= sel;
            end
            state <= in_tlast ? axis_mode_pkg::IDLE : axis_mode_pkg::IN_PKT;
        end
    end

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        localparam logic [SEL_W-1:0] PORT_ID = SEL_W'(p);

        assign slice_tvalid[p] = in_tvalid && (cur_port == PORT_ID);

        axis_fwd_register #(
            .DATA_BYTES (DATA_BYTES),
            .PIPE_MODE  (PIPE_MODE)
        ) u_slice (
            .axi4s_if_from_tx (axi4s_if_from_tx),
            .aresetn          (aresetn),
            .in_tvalid        (slice_tvalid[p]),
            .in_tready        (slice_tready[p]),
            .in_tdata         (in_tdata),
            .in_tkeep         (in_tkeep),
            .in_tlast         (in_tlast),
            .out_tvalid       (out_tvalid[p]),
            .out_tready       (out_tready[p]),
            .out_tdata        (out_tdata[p]),
            .out_tkeep        (out_tkeep[p]),
            .out_tlast        (out_tlast[p])
        );
    end

endmodule

`default_nettype wire

/* axis_stream_path.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_stream_path #(
    parameter int                       DATA_BYTES = axis_cfg_pkg::DATA_BYTES_DEF,
    parameter int                       NUM_PORTS  = axis_cfg_pkg::NUM_PORTS_DEF,
    parameter axis_mode_pkg::fwd_mode_t PIPE_MODE  = axis_mode_pkg::PULL
) (
    input  wire                                  axi4s_if_from_tx,
    input  wire                                  aresetn,
    input  wire                                  in_tvalid,
    output logic                                 in_tready,
    input  wire [DATA_BYTES*axis_cfg_pkg::BYTE_W-1:0] in_tdata,
    input  wire [DATA_BYTES-1:0]                 in_tkeep,
    input  wire                                  in_tlast,
    input  wire [$clog2(NUM_PORTS)-1:0]          sel,
    output logic [NUM_PORTS-1:0]                 out_tvalid,
    input  wire [NUM_PORTS-1:0]                  out_tready,
    output logic [NUM_PORTS-1:0][DATA_BYTES*axis_cfg_pkg::BYTE_W-1:0] out_tdata,
    output logic [NUM_PORTS-1:0][DATA_BYTES-1:0] out_tkeep,
    output logic [NUM_PORTS-1:0]                 out_tlast
);

    localparam int DATA_W = DATA_BYTES * axis_cfg_pkg::BYTE_W;

    // Skid buffer to forward slice
    logic                  skid_tvalid;
    logic                  skid_tready;
    logic [DATA_W-1:0]     skid_tdata;
    logic [DATA_BYTES-1:0] skid_tkeep;
    logic                  skid_tlast;

    // Forward slice to advance stage
    logic                  fwd_tvalid;
    logic                  fwd_tready;
    logic [DATA_W-1:0]     fwd_tdata;
    logic [DATA_BYTES-1:0] fwd_tkeep;
    logic                  fwd_tlast;

    // Advance stage to demux
    logic                  adv_tvalid;
    logic                  adv_tready;
    logic [DATA_W-1:0]     adv_tdata;
    logic [DATA_BYTES-1:0] adv_tkeep;
    logic                  adv_tlast;

    axis_skid_buffer #(
        .DATA_BYTES (DATA_BYTES)
    ) u_skid (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .in_tvalid        (in_tvalid),
        .in_tready        (in_tready),
        .in_tdata         (in_tdata),
        .in_tkeep         (in_tkeep),
        .in_tlast         (in_tlast),
        .out_tvalid       (skid_tvalid),
        .out_tready       (skid_tready),
        .out_tdata        (skid_tdata),
        .out_tkeep        (skid_tkeep),
        .out_tlast        (skid_tlast)
    );

    axis_fwd_register #(
        .DATA_BYTES (DATA_BYTES),
        .PIPE_MODE  (PIPE_MODE)
    ) u_fwd (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .in_tvalid        (skid_tvalid),
        .in_tready        (skid_tready),
        .in_tdata         (skid_tdata),
        .in_tkeep         (skid_tkeep),
        .in_tlast         (skid_tlast),
        .out_tvalid       (fwd_tvalid),
        .out_tready       (fwd_tready),
        .out_tdata        (fwd_tdata),
        .out_tkeep        (fwd_tkeep),
        .out_tlast        (fwd_tlast)
    );

    axis_tlast_advance #(
        .DATA_BYTES (DATA_BYTES),
        .PIPE_MODE  (PIPE_MODE)
    ) u_adv (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .in_tvalid        (fwd_tvalid),
        .in_tready        (fwd_tready),
        .in_tdata         (fwd_tdata),
        .in_tkeep         (fwd_tkeep),
        .in_tlast         (fwd_tlast),
        .out_tvalid       (adv_tvalid),
        .out_tready       (adv_tready),
        .out_tdata        (adv_tdata),
        .out_tkeep        (adv_tkeep),
        .out_tlast        (adv_tlast)
    );

    axis_demux #(
        .DATA_BYTES (DATA_BYTES),
        .NUM_PORTS  (NUM_PORTS),
        .PIPE_MODE  (PIPE_MODE)
    ) u_demux (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .in_tvalid        (adv_tvalid),
        .in_tready        (adv_tready),
        .in_tdata         (adv_tdata),
        .in_tkeep         (adv_tkeep),
        .in_tlast         (adv_tlast),
        .sel              (sel),
        .out_tvalid       (out_tvalid),
        .out_tready       (out_tready),
        .out_tdata        (out_tdata),
        .out_tkeep        (out_tkeep),
        .out_tlast        (out_tlast)
    );

endmodule

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
    parameter int DATA_BYTES = 4,
    parameter int NUM_PORTS  = 2
) (
    input  wire                                  axi4s_if_from_tx,
    input  wire                                  aresetn,
    input  wire                                  in_tvalid,
    input  wire                                  in_tready,
    input  wire [DATA_BYTES*axis_cfg_pkg::BYTE_W-1:0] in_tdata,
    input  wire [DATA_BYTES-1:0]                 in_tkeep,
    input  wire                                  in_tlast,
    input  wire [$clog2(NUM_PORTS)-1:0]          sel,
    input  wire [NUM_PORTS-1:0]                  out_tvalid,
    input  wire [NUM_PORTS-1:0]                  out_tready,
    input  wire [NUM_PORTS-1:0][DATA_BYTES*axis_cfg_pkg::BYTE_W-1:0] out_tdata,
    input  wire [NUM_PORTS-1:0][DATA_BYTES-1:0]  out_tkeep,
    input  wire [NUM_PORTS-1:0]                  out_tlast,
    output int                                   error_count,
    output int                                   beat_count,
    output int                                   outstanding
);

    localparam int DATA_W  = DATA_BYTES * axis_cfg_pkg::BYTE_W;
    localparam int ENTRY_W = DATA_W + DATA_BYTES + 1;
    localparam int SEL_W   = $clog2(NUM_PORTS);

    // Expected beats per port, packed as {tlast, tkeep, tdata}
    logic [ENTRY_W-1:0] exp_q [NUM_PORTS][$];

    logic [ENTRY_W-1:0] held_beat;
    logic               held_valid = 1'b0;
    logic               in_pkt     = 1'b0;
    logic [SEL_W-1:0]   route      = '0;
    int                 post_rst   = 0;
    logic               ready_seen = 1'b0;
    int                 errors     = 0;
    int                 beats      = 0;
    int                 pending    = 0;

    assign error_count = errors;
    assign beat_count  = beats;
    assign outstanding = pending;

    task automatic push_expected(input logic [ENTRY_W-1:0] entry);
        exp_q[route].push_back(entry);
        pending++;
    endtask

    // Reference model of the path for one accepted input beat
    task automatic model_input_beat();
        logic [ENTRY_W-1:0] entry;
        entry = {in_tlast, in_tkeep, in_tdata};
        if (!in_pkt) begin
            route  = sel;
            in_pkt = 1'b1;
        end
        if (in_tlast && in_tkeep == '0) begin
            // Empty closing beat moves its tlast back one beat
            if (held_valid) begin
                held_beat[ENTRY_W-1] = 1'b1;
                push_expected(held_beat);
            end
            held_valid = 1'b0;
        end else begin
            if (held_valid) begin
                push_expected(held_beat);
            end
            held_beat  = entry;
            held_valid = !in_tlast;
            if (in_tlast) begin
                push_expected(entry);
            end
        end
        if (in_tlast) begin
            in_pkt = 1'b0;
        end
    endtask

    task automatic check_output_beat(input int p);
        logic [ENTRY_W-1:0]    entry;
        logic [DATA_W-1:0]     exp_data;
        logic [DATA_BYTES-1:0] exp_keep;
        logic                  exp_last;
        if (exp_q[p].size() == 0) begin
            $display("Unexpected beat on port %0d at %0t, tdata %h", p, $time, out_tdata[p]);
            errors++;
        end else begin
            entry = exp_q[p].pop_front();
            pending--;
            beats++;
            {exp_last, exp_keep, exp_data} = entry;
            if (out_tdata[p] !== exp_data) begin
                $display("[ERROR] %0t out_tdata[%0d] expected %h got %h",
                         $time, p, exp_data, out_tdata[p]);
                errors++;
            end
            if (out_tkeep[p] !== exp_keep) begin
                $display("[ERROR] %0t out_tkeep[%0d] expected %h got %h",
                         $time, p, exp_keep, out_tkeep[p]);
                errors++;
            end
            if (out_tlast[p] !== exp_last) begin
                $display("[ERROR] %0t out_tlast[%0d] expected %b got %b",
                         $time, p, exp_last, out_tlast[p]);
                errors++;
            end
        end
    endtask

    // Mid-cycle sampling, each handshake here completes on the next rising edge
    always @(negedge axi4s_if_from_tx) begin
        if (!aresetn) begin
            post_rst   = 0;
            ready_seen = 1'b0;
        end else begin
            if (post_rst < 2) begin
                if (post_rst == 0 && out_tvalid != '0) begin
                    $display("[ERROR] %0t out_tvalid expected %h got %h",
                             $time, {NUM_PORTS{1'b0}}, out_tvalid);
                    errors++;
                end
                if (in_tready) begin
                    ready_seen = 1'b1;
                end
                if (post_rst == 1 && !ready_seen) begin
                    $display("in_tready did not rise within 2 cycles after reset");
                    errors++;
                end
                post_rst++;
            end
            if (in_tvalid && in_tready) begin
                model_input_beat();
            end
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (out_tvalid[p] && out_tready[p]) begin
                    check_output_beat(p);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    localparam int DATA_BYTES   = axis_cfg_pkg::DATA_BYTES_DEF;
    localparam int NUM_PORTS    = axis_cfg_pkg::NUM_PORTS_DEF;
    localparam int DATA_W       = DATA_BYTES * axis_cfg_pkg::BYTE_W;
    localparam int SEL_W        = $clog2(NUM_PORTS);
    localparam int RAND_PKTS    = 60;
    localparam int STALL_PKTS   = 3;
    localparam int MAX_BEATS    = 6;
    localparam int STALL_CYCLES = 40;
    // Eight cycles per beat at worst, plus reset and drain margin
    localparam int CYCLE_LIMIT  = (RAND_PKTS + STALL_PKTS) * MAX_BEATS * 8 + 200;

    logic                                 axi4s_if_from_tx = 1'b0;
    logic                                 aresetn;
    logic                                 in_tvalid;
    wire                                  in_tready;
    logic [DATA_W-1:0]                    in_tdata;
    logic [DATA_BYTES-1:0]                in_tkeep;
    logic                                 in_tlast;
    logic [SEL_W-1:0]                     sel;
    wire  [NUM_PORTS-1:0]                 out_tvalid;
    logic [NUM_PORTS-1:0]                 out_tready;
    wire  [NUM_PORTS-1:0][DATA_W-1:0]     out_tdata;
    wire  [NUM_PORTS-1:0][DATA_BYTES-1:0] out_tkeep;
    wire  [NUM_PORTS-1:0]                 out_tlast;

    logic [15:0]          lfsr_state;
    logic                 rand_ready_en;
    logic [NUM_PORTS-1:0] hold_low;
    logic                 stall_phase;
    logic                 saw_backpressure = 1'b0;
    int                   drv_errors;
    int                   chk_errors;
    int                   chk_beats;
    int                   chk_outstanding;

    always #5 axi4s_if_from_tx = ~axi4s_if_from_tx;

    axis_stream_path #(
        .DATA_BYTES (DATA_BYTES),
        .NUM_PORTS  (NUM_PORTS),
        .PIPE_MODE  (axis_mode_pkg::PULL)
    ) dut0 (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .in_tvalid        (in_tvalid),
        .in_tready        (in_tready),
        .in_tdata         (in_tdata),
        .in_tkeep         (in_tkeep),
        .in_tlast         (in_tlast),
        .sel              (sel),
        .out_tvalid       (out_tvalid),
        .out_tready       (out_tready),
        .out_tdata        (out_tdata),
        .out_tkeep        (out_tkeep),
        .out_tlast        (out_tlast)
    );

    tb_checker #(
        .DATA_BYTES (DATA_BYTES),
        .NUM_PORTS  (NUM_PORTS)
    ) u_chk (
        .axi4s_if_from_tx (axi4s_if_from_tx),
        .aresetn          (aresetn),
        .in_tvalid        (in_tvalid),
        .in_tready        (in_tready),
        .in_tdata         (in_tdata),
        .in_tkeep         (in_tkeep),
        .in_tlast         (in_tlast),
        .sel              (sel),
        .out_tvalid       (out_tvalid),
        .out_tready       (out_tready),
        .out_tdata        (out_tdata),
        .out_tkeep        (out_tkeep),
        .out_tlast        (out_tlast),
        .error_count      (chk_errors),
        .beat_count       (chk_beats),
        .outstanding      (chk_outstanding)
    );

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic step_cycle();
        @(posedge axi4s_if_from_tx);
        #1;
    endtask

    // Holds the beat until in_tready is seen mid-cycle
    task automatic send_beat(input logic [DATA_W-1:0] data, input logic [DATA_BYTES-1:0] keep,
                             input logic last);
        logic accepted;
        accepted  = 1'b0;
        in_tvalid = 1'b1;
        in_tdata  = data;
        in_tkeep  = keep;
        in_tlast  = last;
        while (!accepted) begin
            @(negedge axi4s_if_from_tx);
            accepted = in_tready;
            step_cycle();
        end
        in_tvalid = 1'b0;
    endtask

    task automatic send_random_packet();
        int                    len;
        int                    gap;
        logic                  empty_only;
        logic                  add_empty;
        logic [DATA_BYTES-1:0] keep;
        logic                  last;
        empty_only = (rand_bits(2) == 32'd0);
        add_empty  = (rand_bits(2) == 32'd0);
        len        = empty_only ? 0 : 1 + int'(rand_bits(3) % 32'd6);
        for (int i = 0; i < len; i++) begin
            gap = int'(rand_bits(2));
            repeat (gap) step_cycle();
            keep = DATA_BYTES'(rand_bits(DATA_BYTES));
            last = (i == len - 1) && !add_empty;
            // Closing beat of a normal packet always carries bytes
            if (last && keep == '0) begin
                keep = '1;
            end
            send_beat(DATA_W'(rand_bits(DATA_W)), keep, last);
        end
        if (empty_only || add_empty) begin
            send_beat(DATA_W'(rand_bits(DATA_W)), '0, 1'b1);
        end
    endtask

    task automatic wait_drained();
        do begin
            step_cycle();
        end while (chk_outstanding != 0);
        repeat (2) step_cycle();
    endtask

    // Long stall on one port while full packets keep coming
    task automatic stall_test();
        logic [SEL_W-1:0] port;
        port           = SEL_W'(rand_bits(SEL_W) % NUM_PORTS);
        sel            = port;
        hold_low[port] = 1'b1;
        stall_phase    = 1'b1;
        fork
            begin
                for (int n = 0; n < STALL_PKTS * MAX_BEATS; n++) begin
                    send_beat(DATA_W'(rand_bits(DATA_W)), '1, (n % MAX_BEATS) == MAX_BEATS - 1);
                end
            end
            begin
                repeat (STALL_CYCLES) step_cycle();
                hold_low = '0;
            end
        join
        stall_phase = 1'b0;
        wait_drained();
        if (!saw_backpressure) begin
            $display("in_tready never dropped while port %0d was stalled", port);
            drv_errors++;
        end
    endtask

    always @(negedge axi4s_if_from_tx) begin
        if (stall_phase && in_tvalid && !in_tready) begin
            saw_backpressure = 1'b1;
        end
    end

    initial begin : ready_driver
        out_tready = '1;
        forever begin
            @(posedge axi4s_if_from_tx);
            #2;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (hold_low[p]) begin
                    out_tready[p] = 1'b0;
                end else if (rand_ready_en) begin
                    // Ready three cycles out of four
                    out_tready[p] = (rand_bits(2) != 32'd0);
                end else begin
                    out_tready[p] = 1'b1;
                end
            end
        end
    end

    initial begin : watchdog
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge axi4s_if_from_tx);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        aresetn       = 1'b0;
        in_tvalid     = 1'b0;
        in_tdata      = '0;
        in_tkeep      = '0;
        in_tlast      = 1'b0;
        sel           = '0;
        lfsr_state    = 16'd24871;
        rand_ready_en = 1'b0;
        hold_low      = '0;
        stall_phase   = 1'b0;
        drv_errors    = 0;
        repeat (8) @(posedge axi4s_if_from_tx);
        #1;
        aresetn = 1'b1;
        repeat (3) step_cycle();
        rand_ready_en = 1'b1;
        for (int n = 0; n < RAND_PKTS; n++) begin
            sel = SEL_W'(rand_bits(SEL_W) % NUM_PORTS);
            send_random_packet();
            wait_drained();
        end
        stall_test();
        repeat (20) step_cycle();
        $display("Run done: %0d beats compared, %0d checker errors, %0d stimulus errors",
                 chk_beats, chk_errors, drv_errors);
        if (chk_errors + drv_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
axis_cfg_pkg.sv
axis_mode_pkg.sv
axis_skid_buffer.sv
axis_fwd_register.sv
axis_tlast_advance.sv
axis_demux.sv
axis_stream_path.sv
tb_checker.sv
tb_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

PASS_MSG  := >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
